// File: logic/wr_engine_pkg.sv
`default_nettype none

package wr_engine_pkg;

    // ========================================================================
    // Engine geometry
    // ========================================================================

    // Channels served by the round-robin arbiter
    localparam int NUM_CHANNELS = 4;
    localparam int CHAN_WIDTH   = 2;

    // Address and data path
    localparam int ADDR_WIDTH   = 32;
    localparam int DATA_WIDTH   = 32;
    localparam int BEAT_BYTES   = 4;
    // Shift that turns a beat count into a byte offset
    localparam int BEAT_SHIFT   = 2;

    // Counter widths
    localparam int LEN_WIDTH    = 8;
    localparam int COUNT_WIDTH  = 8;
    localparam int BEATS_WIDTH  = 16;

    // ========================================================================
    // Data types
    // ========================================================================

    typedef logic [CHAN_WIDTH-1:0]   chan_id_t;
    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [DATA_WIDTH-1:0]   data_t;
    // Burst length in beats, not the AXI len-1 encoding
    typedef logic [LEN_WIDTH-1:0]    len_t;
    // Beats currently held in a channel's SRAM FIFO
    typedef logic [COUNT_WIDTH-1:0]  count_t;
    // Total beats of one descriptor
    typedef logic [BEATS_WIDTH-1:0]  beats_t;
    typedef logic [NUM_CHANNELS-1:0] chan_mask_t;

endpackage

`default_nettype wire

// File: logic/axi_defs_pkg.sv
`default_nettype none

package axi_defs_pkg;

    // ========================================================================
    // AXI4 master port fields
    // ========================================================================

    // Transaction ID, channel index sits in the low bits
    localparam int ID_WIDTH = 4;

    typedef logic [ID_WIDTH-1:0] axi_id_t;
    typedef logic [1:0]          axi_burst_t;
    typedef logic [2:0]          axi_size_t;

    // Burst type codes
    localparam axi_burst_t BURST_INCR = 2'b01;

    // Size code is log2 of bytes per beat, 4 bytes here
    localparam axi_size_t AXI_SIZE_BEAT = 3'b010;

endpackage

`default_nettype wire

// File: logic/channel_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module channel_arbiter
    import wr_engine_pkg::*;
(
    input  wire                           clk,
    input  wire                           arst_n,
    // Per-channel request state
    input  wire chan_mask_t               sched_valid,
    input  wire count_t [NUM_CHANNELS-1:0] data_available,
    input  wire len_t                     xfer_beats,
    input  wire chan_mask_t               outstanding,
    // Sequencer accepts the offered channel
    input  wire                           grant_take,
    output logic                          grant_valid,
    output chan_id_t                      grant_id
);

    // ========================================================================
    // Eligibility
    // ========================================================================

    chan_mask_t eligible;
    // Channel taken most recently, search starts one past it
    chan_id_t   last_id;

    always_comb begin
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            // Requesting, a whole burst in the SRAM, nothing in flight
            eligible[c] = sched_valid[c]
                       && (data_available[c] >= count_t'(xfer_beats))
                       && !outstanding[c];
        end
    end

    // ========================================================================
    // Round-robin search
    // ========================================================================

    // Walk the ring from last_id + 1, first eligible channel wins
    always_comb begin
        chan_id_t idx;
        idx         = '0;
        grant_valid = 1'b0;
        grant_id    = '0;
        for (int off = 1; off <= NUM_CHANNELS; off++) begin
            // Index wraps in CHAN_WIDTH bits, last_id itself comes last
            idx = last_id + chan_id_t'(off);
            if (!grant_valid && eligible[idx]) begin
                grant_valid = 1'b1;
                grant_id    = idx;
            end
        end
    end

    // Pointer only moves when the sequencer takes the grant
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            // First search after reset starts at channel 0
            last_id <= chan_id_t'(NUM_CHANNELS - 1);
        end else if (grant_take) begin
            last_id <= grant_id;
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================

    a_grant_eligible: assert property (@(posedge clk) disable iff (!arst_n)
        grant_valid |-> eligible[grant_id]);

    // Sequencer must never take a grant that is not on offer
    a_take_offered: assert property (@(posedge clk) disable iff (!arst_n)
        grant_take |-> grant_valid);

endmodule

`default_nettype wire

// File: logic/burst_progress.sv
`timescale 1ns/1ps
`default_nettype none

module burst_progress
    import wr_engine_pkg::*;
(
    input  wire                            clk,
    input  wire                            arst_n,
    // Scheduler descriptors
    input  wire chan_mask_t                sched_valid,
    input  wire addr_t  [NUM_CHANNELS-1:0] sched_addr,
    input  wire beats_t [NUM_CHANNELS-1:0] sched_beats,
    input  wire len_t                      xfer_beats,
    // Channel on offer from the arbiter
    input  wire chan_id_t                  grant_id,
    // AW and B handshakes
    input  wire                            aw_fire,
    input  wire chan_id_t                  aw_chan,
    input  wire                            b_fire,
    input  wire chan_id_t                  b_chan,
    output chan_mask_t                     outstanding,
    output addr_t                          next_addr,
    output chan_mask_t                     sched_ready,
    output chan_mask_t                     done_strobe,
    output len_t   [NUM_CHANNELS-1:0]      beats_done
);

    // ========================================================================
    // Per-channel beat counters
    // ========================================================================

    // Beats covered by AW handshakes so far
    beats_t [NUM_CHANNELS-1:0] issued;
    // Beats confirmed by B responses so far
    beats_t [NUM_CHANNELS-1:0] written;
    // One-hot handshake decode
    chan_mask_t aw_hit;
    chan_mask_t b_hit;
    // Written count of the responding channel after this B
    beats_t     written_next;

    always_comb begin
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            aw_hit[c] = aw_fire && (aw_chan == chan_id_t'(c));
            b_hit[c]  = b_fire && (b_chan == chan_id_t'(c));
        end
    end

    assign written_next = written[b_chan] + beats_t'(xfer_beats);

    // Next burst of the offered channel starts after the beats already issued
    assign next_addr = sched_addr[grant_id] + (addr_t'(issued[grant_id]) << BEAT_SHIFT);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            issued      <= '0;
            written     <= '0;
            outstanding <= '0;
        end else begin
            for (int c = 0; c < NUM_CHANNELS; c++) begin
                // Idle channel, restart counting for the next descriptor
                if (!sched_valid[c]) begin
                    issued[c]  <= '0;
                    written[c] <= '0;
                end else begin
                    if (aw_hit[c]) begin
                        issued[c] <= issued[c] + beats_t'(xfer_beats);
                    end
                    if (b_hit[c]) begin
                        written[c] <= written[c] + beats_t'(xfer_beats);
                    end
                end
                // One write in flight per channel
                if (aw_hit[c]) begin
                    outstanding[c] <= 1'b1;
                end
                if (b_hit[c]) begin
                    outstanding[c] <= 1'b0;
                end
            end
        end
    end

    // ========================================================================
    // Completion pulses
    // ========================================================================

    // Both pulses land one cycle after the B handshake
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            done_strobe <= '0;
            sched_ready <= '0;
        end else begin
            done_strobe <= b_hit;
            // Descriptor finished once this B covers all its beats
            sched_ready <= b_hit & {NUM_CHANNELS{written_next >= sched_beats[b_chan]}};
        end
    end

    // Beats reported with each strobe, every burst has the configured length
    always_ff @(posedge clk) begin
        for (int c = 0; c < NUM_CHANNELS; c++) begin
            if (b_hit[c]) begin
                beats_done[c] <= xfer_beats;
            end
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================

    a_b_has_aw: assert property (@(posedge clk) disable iff (!arst_n)
        b_fire |-> outstanding[b_chan]);

    // Arbiter masking must keep a busy channel off the AW channel
    a_single_aw: assert property (@(posedge clk) disable iff (!arst_n)
        aw_fire |-> !outstanding[aw_chan]);

endmodule

`default_nettype wire

// File: logic/burst_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module burst_sequencer
    import wr_engine_pkg::*;
    import axi_defs_pkg::*;
(
    input  wire              clk,
    input  wire              arst_n,
    // Arbiter offer and the address for it
    input  wire              grant_valid,
    input  wire chan_id_t    grant_id,
    input  wire addr_t       next_addr,
    input  wire len_t        xfer_beats,
    // AXI handshakes
    input  wire              awready,
    input  wire              wready,
    // Per-channel SRAM read valid
    input  wire chan_mask_t  sram_valid,
    output logic             grant_take,
    output logic             aw_fire,
    output chan_id_t         aw_chan,
    output logic             awvalid,
    output addr_t            awaddr,
    output len_t             awlen,
    output logic             wvalid,
    output logic             wlast,
    output logic             sram_drain,
    output chan_id_t         sram_id
);

    // ========================================================================
    // Burst FSM
    // ========================================================================

    typedef enum logic [1:0] {
        S_IDLE,
        S_ADDR,
        S_DATA
    } seq_state_t;

    seq_state_t state;
    // Channel of the burst being issued or streamed
    chan_id_t   chan;
    // Beats left after the current one, zero on the last beat
    len_t       beats_left;
    logic       w_fire;

    // Take a grant only while idle
    assign grant_take = (state == S_IDLE) && grant_valid;

    // AW side
    assign awvalid = (state == S_ADDR);
    assign aw_fire = awvalid && awready;
    assign aw_chan = chan;

    // W side follows the SRAM valid of the active channel
    assign wvalid     = (state == S_DATA) && sram_valid[chan];
    assign wlast      = (state == S_DATA) && (beats_left == '0);
    assign w_fire     = wvalid && wready;
    // Pop the SRAM only on a real W handshake
    assign sram_drain = w_fire;
    assign sram_id    = chan;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= S_IDLE;
            chan       <= '0;
            beats_left <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (grant_take) begin
                        state <= S_ADDR;
                        chan  <= grant_id;
                    end
                end
                S_ADDR: begin
                    // Count from awlen down to zero
                    if (aw_fire) begin
                        state      <= S_DATA;
                        beats_left <= awlen;
                    end
                end
                S_DATA: begin
                    if (w_fire) begin
                        if (wlast) begin
                            state <= S_IDLE;
                        end else begin
                            beats_left <= beats_left - len_t'(1);
                        end
                    end
                end
                default: begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    // AW fields captured with the grant, held through back-pressure
    always_ff @(posedge clk) begin
        if (grant_take) begin
            awaddr <= next_addr;
            awlen  <= xfer_beats - len_t'(1);
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================

    a_aw_stable: assert property (@(posedge clk) disable iff (!arst_n)
        awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awlen)
                                && $stable(aw_chan));

    // wlast rises in the data state only after a W beat or the AW of a one-beat burst
    a_wlast_in_data: assert property (@(posedge clk) disable iff (!arst_n)
        $rose(wlast) |-> (state == S_DATA)
                         && ($past(w_fire) || ($past(aw_fire) && (awlen == '0))));

endmodule

`default_nettype wire

// File: logic/axi_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module axi_write_engine
    import wr_engine_pkg::*;
    import axi_defs_pkg::*;
(
    input  wire                            clk,
    input  wire                            arst_n,
    // Configuration
    input  wire len_t                      cfg_xfer_beats,
    // Scheduler
    input  wire chan_mask_t                sched_valid,
    input  wire addr_t  [NUM_CHANNELS-1:0] sched_addr,
    input  wire beats_t [NUM_CHANNELS-1:0] sched_beats,
    output chan_mask_t                     sched_ready,
    output chan_mask_t                     done_strobe,
    output len_t   [NUM_CHANNELS-1:0]      beats_done,
    // SRAM read port
    input  wire count_t [NUM_CHANNELS-1:0] data_available,
    input  wire chan_mask_t                sram_valid,
    input  wire data_t                     sram_data,
    output logic                           sram_drain,
    output chan_id_t                       sram_id,
    // AXI4 AW
    output axi_id_t                        awid,
    output addr_t                          awaddr,
    output len_t                           awlen,
    output axi_size_t                      awsize,
    output axi_burst_t                     awburst,
    output logic                           awvalid,
    input  wire                            awready,
    // AXI4 W
    output data_t                          wdata,
    output logic [BEAT_BYTES-1:0]          wstrb,
    output logic                           wlast,
    output logic                           wvalid,
    input  wire                            wready,
    // AXI4 B, response code is not acted on
    input  wire axi_id_t                   bid,
    input  wire [1:0]                      bresp,
    input  wire                            bvalid,
    output logic                           bready
);

    // ========================================================================
    // Internal nets
    // ========================================================================

    logic       grant_valid;
    chan_id_t   grant_id;
    logic       grant_take;
    chan_mask_t outstanding;
    addr_t      next_addr;
    logic       aw_fire;
    chan_id_t   aw_chan;
    logic       b_fire;
    chan_id_t   b_chan;

    // Channel index rides in the low bits of the AXI ID
    assign awid    = {{(ID_WIDTH - CHAN_WIDTH){1'b0}}, aw_chan};
    assign awsize  = AXI_SIZE_BEAT;
    assign awburst = BURST_INCR;
    // SRAM data is already muxed by sram_id
    assign wdata   = sram_data;
    assign wstrb   = '1;
    assign bready  = 1'b1;
    // B routes back by ID, bresp is accepted as is
    assign b_fire  = bvalid && bready;
    assign b_chan  = bid[CHAN_WIDTH-1:0];

    channel_arbiter arbiter_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .sched_valid    (sched_valid),
        .data_available (data_available),
        .xfer_beats     (cfg_xfer_beats),
        .outstanding    (outstanding),
        .grant_take     (grant_take),
        .grant_valid    (grant_valid),
        .grant_id       (grant_id)
    );

    burst_progress progress_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .sched_valid (sched_valid),
        .sched_addr  (sched_addr),
        .sched_beats (sched_beats),
        .xfer_beats  (cfg_xfer_beats),
        .grant_id    (grant_id),
        .aw_fire     (aw_fire),
        .aw_chan     (aw_chan),
        .b_fire      (b_fire),
        .b_chan      (b_chan),
        .outstanding (outstanding),
        .next_addr   (next_addr),
        .sched_ready (sched_ready),
        .done_strobe (done_strobe),
        .beats_done  (beats_done)
    );

    burst_sequencer sequencer_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .grant_valid (grant_valid),
        .grant_id    (grant_id),
        .next_addr   (next_addr),
        .xfer_beats  (cfg_xfer_beats),
        .awready     (awready),
        .wready      (wready),
        .sram_valid  (sram_valid),
        .grant_take  (grant_take),
        .aw_fire     (aw_fire),
        .aw_chan     (aw_chan),
        .awvalid     (awvalid),
        .awaddr      (awaddr),
        .awlen       (awlen),
        .wvalid      (wvalid),
        .wlast       (wlast),
        .sram_drain  (sram_drain),
        .sram_id     (sram_id)
    );

endmodule

`default_nettype wire

// File: test/tb_axi_write_engine.sv
`timescale 1ns/1ps
`default_nettype none

module tb_axi_write_engine
    import wr_engine_pkg::*;
();

    // ========================================================================
    // DUT ports
    // ========================================================================

    logic                      clk;
    logic                      arst_n;
    len_t                      cfg_xfer_beats;
    chan_mask_t                sched_valid;
    addr_t  [NUM_CHANNELS-1:0] sched_addr;
    beats_t [NUM_CHANNELS-1:0] sched_beats;
    chan_mask_t                sched_ready;
    chan_mask_t                done_strobe;
    len_t   [NUM_CHANNELS-1:0] beats_done;
    count_t [NUM_CHANNELS-1:0] data_available;
    chan_mask_t                sram_valid;
    data_t                     sram_data;
    logic                      sram_drain;
    chan_id_t                  sram_id;
    logic [3:0]                awid;
    addr_t                     awaddr;
    len_t                      awlen;
    logic [2:0]                awsize;
    logic [1:0]                awburst;
    logic                      awvalid;
    logic                      awready;
    data_t                     wdata;
    logic [BEAT_BYTES-1:0]     wstrb;
    logic                      wlast;
    logic                      wvalid;
    logic                      wready;
    logic [3:0]                bid;
    logic [1:0]                bresp;
    logic                      bvalid;
    logic                      bready;

    // ========================================================================
    // Scheduler, SRAM and slave model state
    // ========================================================================

    logic [31:0] vec [0:255];
    int          vec_ptr;
    int          n_tests;
    int          xfer;
    addr_t       base        [NUM_CHANNELS];
    int          exp_bursts  [NUM_CHANNELS];
    // Beats held in each SRAM and beats still to be written into it
    int          cnt         [NUM_CHANNELS];
    int          supply_left [NUM_CHANNELS];
    // Read position of the SRAM and next beat expected on W
    int          sram_pos    [NUM_CHANNELS];
    int          w_pos       [NUM_CHANNELS];
    int          aw_cnt      [NUM_CHANNELS];
    int          b_cnt       [NUM_CHANNELS];
    chan_mask_t  outst;
    chan_mask_t  elig_prev;
    chan_mask_t  exp_done;
    chan_mask_t  exp_ready;
    logic        awvalid_prev;
    int          last_ch;
    int          w_chan;
    int          w_beat;
    logic        w_active;
    // Pending B responses in AW order, with the cycle each may go out
    int          bq_chan [$];
    int          bq_due  [$];
    logic [31:0] rng;
    int          cyc;
    int          limit;
    int          errors;
    int          checks;
    int          test_bursts;

    axi_write_engine axi_write_engine_i (
        .clk            (clk),
        .arst_n         (arst_n),
        .cfg_xfer_beats (cfg_xfer_beats),
        .sched_valid    (sched_valid),
        .sched_addr     (sched_addr),
        .sched_beats    (sched_beats),
        .sched_ready    (sched_ready),
        .done_strobe    (done_strobe),
        .beats_done     (beats_done),
        .data_available (data_available),
        .sram_valid     (sram_valid),
        .sram_data      (sram_data),
        .sram_drain     (sram_drain),
        .sram_id        (sram_id),
        .awid           (awid),
        .awaddr         (awaddr),
        .awlen          (awlen),
        .awsize         (awsize),
        .awburst        (awburst),
        .awvalid        (awvalid),
        .awready        (awready),
        .wdata          (wdata),
        .wstrb          (wstrb),
        .wlast          (wlast),
        .wvalid         (wvalid),
        .wready         (wready),
        .bid            (bid),
        .bresp          (bresp),
        .bvalid         (bvalid),
        .bready         (bready)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // ========================================================================
    // Helpers
    // ========================================================================

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // First set bit of the mask, searching from one past last
    function automatic int first_in_ring(input chan_mask_t mask, input int last);
        int idx;
        for (int off = 1; off <= NUM_CHANNELS; off++) begin
            idx = (last + off) % NUM_CHANNELS;
            if (mask[idx]) begin
                return idx;
            end
        end
        return -1;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error: %s is 0x%0h, expected 0x%0h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic flag_failure(input string what);
        errors++;
        $display("%s (cycle %0d)", what, cyc);
    endtask

    // Descriptor words: xfer, then base, beats, initial count, bursts per channel
    task automatic load_test();
        int need;
        xfer = int'(vec[vec_ptr]);
        vec_ptr++;
        cfg_xfer_beats <= len_t'(xfer);
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            base[i]        = addr_t'(vec[vec_ptr]);
            sched_addr[i]  <= addr_t'(vec[vec_ptr]);
            sched_beats[i] <= beats_t'(vec[vec_ptr + 1]);
            sched_valid[i] <= (vec[vec_ptr + 1] != 0);
            exp_bursts[i]  = int'(vec[vec_ptr + 3]);
            // SRAM only ever holds whole bursts of this channel
            need           = exp_bursts[i] * xfer;
            cnt[i]         = (int'(vec[vec_ptr + 2]) < need) ? int'(vec[vec_ptr + 2]) : need;
            supply_left[i] = need - cnt[i];
            data_available[i] <= count_t'(cnt[i]);
            sram_valid[i]     <= (cnt[i] != 0);
            sram_pos[i]    = 0;
            w_pos[i]       = 0;
            aw_cnt[i]      = 0;
            b_cnt[i]       = 0;
            vec_ptr        = vec_ptr + 4;
        end
        sram_data <= data_t'(int'(sram_id) * 256);
    endtask

    // ========================================================================
    // One clock edge of the models, reading values from before the edge
    // ========================================================================

    task automatic model_step();
        chan_mask_t elig;
        logic       quiet;
        logic       w_fire;
        int         c;
        int         exp_c;
        cyc++;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            elig[i] = sched_valid[i] && (cnt[i] >= xfer) && !outst[i];
        end
        // Nothing can move, so the SRAM writer tops up starved channels
        quiet = (elig == '0) && (outst == '0) && !awvalid;

        // Strobes owed for last cycle's B
        check_value("done_strobe", done_strobe, exp_done);
        check_value("sched_ready", sched_ready, exp_ready);
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            if (exp_done[i]) begin
                check_value("beats_done", beats_done[i], xfer);
            end
            // Scheduler lets go once the descriptor is done
            if (sched_ready[i]) begin
                sched_valid[i] <= 1'b0;
            end
        end
        exp_done  = '0;
        exp_ready = '0;

        // AW just raised, the grant came from last cycle's eligible set
        if (awvalid && !awvalid_prev) begin
            exp_c = first_in_ring(elig_prev, last_ch);
            if (exp_c < 0) begin
                flag_failure("AW was raised while no channel was eligible");
            end else begin
                check_value("awid", awid, exp_c);
                last_ch = exp_c;
            end
        end

        if (awvalid && awready) begin
            c = int'(awid[CHAN_WIDTH-1:0]);
            if (cnt[c] < xfer) begin
                flag_failure($sformatf("Channel %0d got an AW with only %0d beats in its SRAM",
                                       c, cnt[c]));
            end
            if (outst[c]) begin
                flag_failure($sformatf("Channel %0d got a second AW before its B", c));
            end
            check_value("awaddr", awaddr, base[c] + addr_t'(aw_cnt[c] * xfer * 4));
            check_value("awlen", awlen, xfer - 1);
            // 4-byte beats, INCR bursts
            check_value("awsize", awsize, 3'b010);
            check_value("awburst", awburst, 2'b01);
            aw_cnt[c]++;
            test_bursts++;
            outst[c] = 1'b1;
            w_chan   = c;
            w_beat   = 0;
            w_active = 1'b1;
        end

        w_fire = wvalid && wready;
        check_value("sram_drain", sram_drain, w_fire);
        if (w_fire) begin
            if (!w_active) begin
                flag_failure("W beat arrived with no AW ahead of it");
            end else begin
                check_value("sram_id", sram_id, w_chan);
                check_value("wdata", wdata, w_chan * 256 + w_pos[w_chan]);
                check_value("wlast", wlast, w_beat == xfer - 1);
                check_value("wstrb", wstrb, 4'hf);
                w_pos[w_chan]++;
                w_beat++;
                if (w_beat == xfer) begin
                    w_active = 1'b0;
                    bq_chan.push_back(w_chan);
                    bq_due.push_back(cyc + int'(rng[8:6]));
                end
            end
        end
        if (sram_drain) begin
            cnt[sram_id]--;
            sram_pos[sram_id]++;
        end

        // B handshake, bready is expected to be tied high
        if (bvalid) begin
            check_value("bready", bready, 1'b1);
            c = bq_chan.pop_front();
            bq_due.delete(0);
            outst[c] = 1'b0;
            b_cnt[c]++;
            exp_done[c]  = 1'b1;
            exp_ready[c] = (b_cnt[c] == exp_bursts[c]);
        end

        if (quiet) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                if (sched_valid[i] && supply_left[i] > 0) begin
                    cnt[i]         = cnt[i] + supply_left[i];
                    supply_left[i] = 0;
                end
            end
        end

        // Drive the next cycle
        rng = xorshift32(rng);
        awready <= rng[0] | rng[1];
        wready  <= rng[2] | rng[3];
        bresp   <= rng[5:4];
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            data_available[i] <= count_t'(cnt[i]);
            sram_valid[i]     <= (cnt[i] != 0);
        end
        sram_data <= data_t'(int'(sram_id) * 256 + sram_pos[sram_id]);
        if (bq_chan.size() > 0 && bq_due[0] <= cyc) begin
            bvalid <= 1'b1;
            bid    <= 4'(bq_chan[0]);
        end else begin
            bvalid <= 1'b0;
        end
        awvalid_prev = awvalid;
        elig_prev    = elig;
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        int   cur_test;
        int   tests_done;
        int   err_start;
        int   p;
        logic done;
        logic timed_out;
        clk            = 1'b0;
        arst_n         = 1'b0;
        cfg_xfer_beats = '0;
        sched_valid    = '0;
        sched_addr     = '0;
        sched_beats    = '0;
        data_available = '0;
        sram_valid     = '0;
        sram_data      = '0;
        awready        = 1'b0;
        wready         = 1'b0;
        bid            = '0;
        bresp          = '0;
        bvalid         = 1'b0;
        rng            = 32'h9a75_272d;
        outst          = '0;
        elig_prev      = '0;
        exp_done       = '0;
        exp_ready      = '0;
        awvalid_prev   = 1'b0;
        w_active       = 1'b0;
        last_ch        = NUM_CHANNELS - 1;
        cyc            = 0;
        errors         = 0;
        checks         = 0;
        tests_done     = 0;
        timed_out      = 1'b0;

        $readmemh("test/write_vectors.txt", vec);
        n_tests = 0;
        if ($isunknown(vec[0]) || vec[0] == 0) begin
            flag_failure("Vector file test/write_vectors.txt is missing or empty");
        end else begin
            n_tests = int'(vec[0]);
        end
        // Four cycles per beat plus 200 per burst, summed over all tests
        limit = 0;
        p     = 1;
        for (int t = 0; t < n_tests; t++) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                limit = limit + int'(vec[p + 4 + 4 * i]) * (4 * int'(vec[p]) + 200);
            end
            p = p + 1 + 4 * NUM_CHANNELS;
        end
        vec_ptr = 1;

        repeat (2) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);
        check_value("awvalid", awvalid, 1'b0);
        check_value("wvalid", wvalid, 1'b0);
        check_value("sram_drain", sram_drain, 1'b0);

        for (cur_test = 0; cur_test < n_tests && !timed_out; cur_test++) begin
            @(posedge clk);
            load_test();
            err_start   = errors;
            test_bursts = 0;
            done        = 1'b0;
            while (!done && !timed_out) begin
                @(posedge clk);
                model_step();
                done      = (sched_valid == '0) && (exp_done == '0);
                timed_out = (cyc >= limit);
            end
            if (done) begin
                tests_done++;
                $display("Test %0d finished: xfer %0d, %0d bursts, %0d errors",
                         cur_test, xfer, test_bursts, errors - err_start);
            end else begin
                $display("Timeout: test %0d still running after %0d cycles", cur_test, cyc);
            end
        end

        $display("Tests finished: %0d of %0d, checks: %0d, errors: %0d",
                 tests_done, n_tests, checks, errors);
        if (errors == 0 && !timed_out && n_tests > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: test/write_vectors.txt
// First word: number of tests. Each test: xfer_beats, then one line per channel
// holding base address, descriptor beats, initial SRAM beats, expected bursts
00000004
// 4-beat bursts, every channel has all its data
00000004
10000000 00000010 00000010 00000004
10010000 00000008 00000008 00000002
10020000 0000000c 0000000c 00000003
10030000 00000004 00000004 00000001
// 8-beat bursts, channel 1 starved, channel 3 runs dry after one burst
00000008
20000000 00000014 00000018 00000003
20000400 00000008 00000002 00000001
20000800 00000003 00000008 00000001
20000c00 00000010 00000008 00000002
// Single-beat bursts, channel 2 idle, channel 1 starts empty
00000001
30000000 00000005 00000005 00000005
30001000 00000003 00000000 00000003
30002000 00000000 00000000 00000000
30003000 00000006 00000006 00000006
// 16-beat bursts, channel 0 half filled, channel 2 needs a partial burst
00000010
40000000 00000020 00000010 00000002
40000100 00000010 00000000 00000001
40000200 00000011 00000020 00000002
40000300 00000020 00000020 00000002

// File: filelist.f
logic/wr_engine_pkg.sv
logic/axi_defs_pkg.sv
logic/channel_arbiter.sv
logic/burst_progress.sv
logic/burst_sequencer.sv
logic/axi_write_engine.sv
test/tb_axi_write_engine.sv
